/* hw/board_status_pkg.sv */
/*
 * Shared widths, LED frame types and LED driver constants for the board
 * status path. Lane n of the frame holds the red LED in its low bit and
 * the green LED in its high bit. Outputs of the driver are active low on
 * the board, so the serializer inverts every bit it sends.
 */
package board_status_pkg;

    // Two QSFP cages, four lanes each
    localparam int LANE_COUNT = 8;
    localparam int LED_COUNT = 2 * LANE_COUNT;

    // Half period of the LED shift clock in clk cycles, minus one
    localparam int LED_PRESCALE = 31;
    localparam bit LED_INVERT = 1'b1;

    // Hold-off after PLL lock and reset release
    localparam int RESET_SYNC_STAGES = 4;

    // Flop depth for the lane and red status crossing
    localparam int SYNC_STAGES = 2;

    typedef logic [LANE_COUNT-1:0] lane_mask_t;

    typedef struct packed {
        logic green;
        logic red;
    } led_pair_t;

    // Lane 0 sits in the low bits
    typedef led_pair_t [LANE_COUNT-1:0] led_frame_t;

    // Pins of the external LED shift register
    typedef struct packed {
        logic d;
        logic ld;
        logic sclk;
    } led_sreg_t;

endpackage

/* hw/lock_reset_sync.sv */
/*
 * Reset hold-off for the LED logic. led_rst_n stays low until rst_n and
 * pll_locked have both been high for RESET_SYNC_STAGES clocks, and drops
 * at the next edge after either of them goes low. pll_locked must already
 * be synchronous to clk or be held stable well beyond one clock.
 */
module lock_reset_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic pll_locked,
    output logic led_rst_n
);

    import board_status_pkg::*;

    localparam int CNT_W = $clog2(RESET_SYNC_STAGES + 1);
    localparam logic [CNT_W-1:0] HOLD_CNT = CNT_W'(RESET_SYNC_STAGES);

    logic [CNT_W-1:0] hold_cnt;
    logic             release_ok;

    // Both conditions must hold for the count to advance
    assign release_ok = rst_n && pll_locked;

    always_ff @(posedge clk) begin
        if (!release_ok) begin
            hold_cnt  <= '0;
            led_rst_n <= 1'b0;
        end else begin
            // Saturate once the hold-off has run out
            if (hold_cnt != HOLD_CNT) begin
                hold_cnt <= hold_cnt + 1'b1;
            end
            led_rst_n <= (hold_cnt == HOLD_CNT);
        end
    end

endmodule

/* hw/led_input_sync.sv */
/*
 * Flop synchronizer for the lane lock and red status vectors. Each bit is
 * crossed on its own, so a multi-bit change may land over two clocks.
 * That is harmless for LEDs; the driver just sends one more frame.
 * Output lags the input by SYNC_STAGES clocks.
 */
module led_input_sync (
    input  logic                        clk,
    input  logic                        led_rst_n,
    input  board_status_pkg::lane_mask_t lane_block_lock,
    input  board_status_pkg::lane_mask_t led_red,
    output board_status_pkg::lane_mask_t lock_sync,
    output board_status_pkg::lane_mask_t red_sync
);

    import board_status_pkg::*;

    // Both vectors cross together in one chain
    typedef struct packed {
        lane_mask_t lock;
        lane_mask_t red;
    } sync_word_t;

    sync_word_t sync_chain [SYNC_STAGES];

    always_ff @(posedge clk) begin
        if (!led_rst_n) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_chain[i] <= '0;
            end
        end else begin
            sync_chain[0].lock <= lane_block_lock;
            sync_chain[0].red  <= led_red;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_chain[i] <= sync_chain[i-1];
            end
        end
    end

    assign lock_sync = sync_chain[SYNC_STAGES-1].lock;
    assign red_sync  = sync_chain[SYNC_STAGES-1].red;

endmodule

/* hw/led_sreg_driver.sv */
/*
 * Serializer for the external LED shift register. A frame goes out MSB
 * first, each bit inverted when LED_INVERT is set, followed by one shift
 * clock period of ld with sclk low. A frame is sent once after reset and
 * then only when the input frame differs from the last one sent. Input
 * changes during a frame are picked up once the frame has ended.
 */
module led_sreg_driver (
    input  logic                        clk,
    input  logic                        led_rst_n,
    input  board_status_pkg::led_frame_t frame,
    output board_status_pkg::led_sreg_t  led_sreg
);

    import board_status_pkg::*;

    localparam int PRESC_W = $clog2(LED_PRESCALE + 1);
    localparam int BIT_W = $clog2(LED_COUNT);
    localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(LED_PRESCALE);
    localparam logic [BIT_W-1:0] BIT_FIRST = BIT_W'(LED_COUNT - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_LOAD
    } state_t;

    state_t state;

    led_sreg_t pins;

    logic [PRESC_W-1:0]   presc_cnt;
    logic                 tick;
    logic [BIT_W-1:0]     bit_cnt;
    logic                 load_phase;
    logic                 force_first;
    logic                 start_frame;

    logic [LED_COUNT-1:0] frame_bits;
    logic [LED_COUNT-1:0] shift_data;
    led_frame_t           last_sent;

    assign frame_bits = frame;

    // One tick per half period of the shift clock
    assign tick = (presc_cnt == PRESC_LAST);

    // First frame after reset is sent unconditionally
    assign start_frame = (state == ST_IDLE) && (force_first || (frame != last_sent));

    always_ff @(posedge clk) begin
        if (!led_rst_n) begin
            state       <= ST_IDLE;
            presc_cnt   <= '0;
            bit_cnt     <= '0;
            load_phase  <= 1'b0;
            force_first <= 1'b1;
            pins        <= '0;
        end else begin
            // Prescaler runs only while a frame is in flight
            if (state == ST_IDLE || tick) begin
                presc_cnt <= '0;
            end else begin
                presc_cnt <= presc_cnt + 1'b1;
            end

            case (state)
                ST_IDLE: begin
                    if (start_frame) begin
                        // Top bit is set up during the first low half
                        force_first <= 1'b0;
                        bit_cnt     <= BIT_FIRST;
                        pins.d      <= frame_bits[LED_COUNT-1] ^ LED_INVERT;
                        pins.sclk   <= 1'b0;
                        pins.ld     <= 1'b0;
                        state       <= ST_SHIFT;
                    end
                end

                ST_SHIFT: begin
                    if (tick) begin
                        if (!pins.sclk) begin
                            // Register samples d on this rising edge
                            pins.sclk <= 1'b1;
                        end else begin
                            pins.sclk <= 1'b0;
                            if (bit_cnt == '0) begin
                                pins.d     <= 1'b0;
                                pins.ld    <= 1'b1;
                                load_phase <= 1'b0;
                                state      <= ST_LOAD;
                            end else begin
                                bit_cnt <= bit_cnt - 1'b1;
                                pins.d  <= shift_data[LED_COUNT-2] ^ LED_INVERT;
                            end
                        end
                    end
                end

                ST_LOAD: begin
                    // ld spans two half periods
                    if (tick) begin
                        if (!load_phase) begin
                            load_phase <= 1'b1;
                        end else begin
                            pins.ld <= 1'b0;
                            state   <= ST_IDLE;
                        end
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Frame payload and the copy used for change detection
    always_ff @(posedge clk) begin
        if (start_frame) begin
            shift_data <= frame_bits;
            last_sent  <= frame;
        end else if (state == ST_SHIFT && tick && pins.sclk) begin
            shift_data <= shift_data << 1;
        end
    end

    assign led_sreg = pins;

endmodule

/* hw/board_status_top.sv */
/*
 * Board status LED path. Lane block lock drives the green LEDs and the
 * core's red status bits drive the red LEDs, interleaved red on bit 2n
 * and green on bit 2n+1. Both input vectors may come from any clock
 * domain. Nothing is sent until the board PLL is locked and reset has
 * been released for the hold-off time.
 */
module board_status_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pll_locked,
    input  board_status_pkg::lane_mask_t lane_block_lock,
    input  board_status_pkg::lane_mask_t led_red,
    output board_status_pkg::led_sreg_t  led_sreg
);

    import board_status_pkg::*;

    logic       led_rst_n;
    lane_mask_t lock_sync;
    lane_mask_t red_sync;
    led_frame_t led_frame;

    lock_reset_sync lock_reset_sync_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .pll_locked (pll_locked),
        .led_rst_n  (led_rst_n)
    );

    led_input_sync led_input_sync_inst (
        .clk             (clk),
        .led_rst_n       (led_rst_n),
        .lane_block_lock (lane_block_lock),
        .led_red         (led_red),
        .lock_sync       (lock_sync),
        .red_sync        (red_sync)
    );

    // Pair n carries red and green of lane n
    always_comb begin
        for (int n = 0; n < LANE_COUNT; n++) begin
            led_frame[n].red   = red_sync[n];
            led_frame[n].green = lock_sync[n];
        end
    end

    led_sreg_driver led_sreg_driver_inst (
        .clk       (clk),
        .led_rst_n (led_rst_n),
        .frame     (led_frame),
        .led_sreg  (led_sreg)
    );

endmodule

/* tests/tb_board_status_tasks.svh */
/*
 * Stimulus, wait, compare and directed test tasks for tb_board_status.
 * Included inside the testbench module and works on its signals directly.
 * Every test expects the driver to be idle when it starts and leaves it
 * idle when it returns.
 */
`ifndef TB_BOARD_STATUS_TASKS_SVH
`define TB_BOARD_STATUS_TASKS_SVH

// Drive point just after the next rising edge
task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DELAY);
endtask

task automatic wait_cycles(input int n);
    repeat (n) begin
        next_cycle();
    end
endtask

task automatic drive_inputs(input lane_mask_t lock, input lane_mask_t red);
    lane_block_lock = lock;
    led_red         = red;
endtask

// Red lane n on bit 2n, green lane n on bit 2n+1, LEDs active low
function automatic led_frame_t expected_latch(input lane_mask_t lock, input lane_mask_t red);
    logic [LED_COUNT-1:0] bits;
    for (int n = 0; n < LANE_COUNT; n++) begin
        bits[2*n]     = red[n];
        bits[2*n + 1] = lock[n];
    end
    return led_frame_t'(~bits);
endfunction

task automatic check_frame(input led_frame_t got, input led_frame_t exp, input string msg);
    if (got !== exp) begin
        value_errors++;
        $display("FAILED @%0t: %s latched %h, expected %h", $time, msg, got, exp);
    end
endtask

task automatic check_pins(input led_sreg_t got, input led_sreg_t exp, input string msg);
    if (got !== exp) begin
        value_errors++;
        $display("FAILED @%0t: %s pins d/ld/sclk %b, expected %b", $time, msg, got, exp);
    end
endtask

// Next latch, then ld back low so the driver is idle again
task automatic wait_for_frame(input string msg, output bit seen);
    int start_count;
    int waited;
    start_count = ld_count;
    waited = 0;
    while (ld_count == start_count && waited < FRAME_TIMEOUT) begin
        next_cycle();
        waited++;
    end
    seen = (ld_count != start_count);
    if (!seen) begin
        frame_errors++;
        $display("No ld pulse within %0d clocks for %s at time %0t",
                 FRAME_TIMEOUT, msg, $time);
    end else begin
        while (sreg_ld) begin
            next_cycle();
        end
    end
endtask

task automatic expect_frame(input lane_mask_t lock, input lane_mask_t red, input string msg);
    bit seen;
    wait_for_frame(msg, seen);
    if (seen) begin
        check_frame(latched, expected_latch(lock, red), msg);
    end
endtask

task automatic send_pattern(input lane_mask_t lock, input lane_mask_t red, input string msg);
    drive_inputs(lock, red);
    expect_frame(lock, red, msg);
endtask

task automatic reset_state_test();
    rst_n      = 1'b0;
    pll_locked = 1'b1;
    drive_inputs('0, '0);
    // Pins reach reset two clocks in
    wait_cycles(2);
    for (int i = 2; i < RESET_CYCLES; i++) begin
        check_pins(led_sreg, '0, "during reset");
        next_cycle();
    end
    rst_n = 1'b1;
    expect_frame('0, '0, "first frame after reset");
endtask

task automatic lock_mapping_test();
    lane_mask_t patterns [$];
    for (int n = 0; n < LANE_COUNT; n++) begin
        patterns.push_back(lane_mask_t'(1) << n);
    end
    patterns.push_back(8'hA5);
    patterns.push_back(8'h3C);
    patterns.push_back(8'hFF);
    patterns.push_back(8'h00);
    foreach (patterns[i]) begin
        send_pattern(patterns[i], '0, $sformatf("lock pattern %h", patterns[i]));
    end
endtask

task automatic red_mapping_test();
    lane_mask_t lock;
    lane_mask_t red;
    for (int i = 0; i < 8; i++) begin
        // Redraw if nothing would change
        do begin
            lock = lane_mask_t'($random(seed));
            red  = lane_mask_t'($random(seed));
        end while (lock == lane_block_lock && red == led_red);
        send_pattern(lock, red, $sformatf("random lock %h red %h", lock, red));
    end
endtask

task automatic lock_loss_test();
    lane_mask_t lock;
    lane_mask_t red;
    int         start_count;
    lock = lane_block_lock ^ 8'h5A;
    red  = 8'h81;
    start_count = ld_count;
    drive_inputs(lock, red);
    // A few bits out before the PLL drops
    wait_cycles(6 * 2 * (LED_PRESCALE + 1));
    pll_locked = 1'b0;
    wait_cycles(2);
    check_pins(led_sreg, '0, "after lock loss");
    // Long enough for a frame that kept running to reach its ld pulse
    wait_cycles(FRAME_CYCLES);
    check_pins(led_sreg, '0, "while unlocked");
    if (ld_count != start_count) begin
        value_errors++;
        $display("FAILED @%0t: aborted frame still produced an ld pulse", $time);
    end
    pll_locked = 1'b1;
    // Synchronizer restarts cleared, so all LEDs off comes first
    expect_frame('0, '0, "first frame after relock");
    expect_frame(lock, red, "frame after relock");
endtask

task automatic idle_hold_test();
    lane_mask_t lock;
    int         start_count;
    start_count = ld_count;
    wait_cycles(3 * FRAME_CYCLES);
    if (ld_count != start_count) begin
        value_errors++;
        $display("FAILED @%0t: %0d frames sent with inputs unchanged",
                 $time, ld_count - start_count);
    end
    lock = lane_block_lock ^ 8'h10;
    send_pattern(lock, led_red, "single bit change");
    wait_cycles(FRAME_CYCLES);
    if (ld_count != start_count + 1) begin
        value_errors++;
        $display("FAILED @%0t: %0d frames after a single bit change, expected 1",
                 $time, ld_count - start_count);
    end
endtask

`endif

/* tests/tb_board_status.sv */
/*
 * Testbench for board_status_top. A model of the external LED shift
 * register shifts d in on each rising sclk and latches on each rising ld.
 * Inputs change only while the driver is idle, so every frame carries one
 * known pattern. A watchdog bounds the run at 20 frame times per test.
 */
module tb_board_status;

    import board_status_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 5;
    localparam int RESET_CYCLES = 10;
    localparam int TEST_COUNT = 5;

    // LED_COUNT bits plus the load period, two half periods each
    localparam int FRAME_CYCLES = (LED_COUNT + 1) * 2 * (LED_PRESCALE + 1);
    localparam int FRAME_TIMEOUT = 3 * FRAME_CYCLES;
    localparam longint WATCHDOG_TIME =
        longint'(TEST_COUNT) * 20 * FRAME_CYCLES * CLK_PERIOD;

    logic       clk;
    logic       rst_n;
    logic       pll_locked;
    lane_mask_t lane_block_lock;
    lane_mask_t led_red;
    led_sreg_t  led_sreg;

    // Single pins for edge detection in the register model
    logic sreg_d;
    logic sreg_ld;
    logic sreg_sclk;

    logic [LED_COUNT-1:0] sreg_bits;
    led_frame_t           latched;
    int                   ld_count;

    int     value_errors;
    int     frame_errors;
    integer seed;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    board_status_top dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .pll_locked      (pll_locked),
        .lane_block_lock (lane_block_lock),
        .led_red         (led_red),
        .led_sreg        (led_sreg)
    );

    assign sreg_d    = led_sreg.d;
    assign sreg_ld   = led_sreg.ld;
    assign sreg_sclk = led_sreg.sclk;

    // External shift register, first bit ends up in the top position
    always @(posedge sreg_sclk) begin
        sreg_bits <= {sreg_bits[LED_COUNT-2:0], sreg_d};
    end

    always @(posedge sreg_ld) begin
        latched  <= led_frame_t'(sreg_bits);
        ld_count <= ld_count + 1;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired at time %0t, the test sequence did not finish", $time);
        $display("CHECKS FAILED");
        $finish;
    end

    `include "tb_board_status_tasks.svh"

    initial begin
        value_errors    = 0;
        frame_errors    = 0;
        ld_count        = 0;
        seed            = 32'h8e59_2bb6;
        rst_n           = 1'b0;
        pll_locked      = 1'b1;
        lane_block_lock = '0;
        led_red         = '0;

        reset_state_test();
        lock_mapping_test();
        red_mapping_test();
        lock_loss_test();
        idle_hold_test();

        $display("Done: %0d value errors, %0d missing frames, %0d frames latched",
                 value_errors, frame_errors, ld_count);
        if (value_errors + frame_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+tests
hw/board_status_pkg.sv
hw/lock_reset_sync.sv
hw/led_input_sync.sv
hw/led_sreg_driver.sv
hw/board_status_top.sv
tests/tb_board_status.sv

/* Bender.yml */
package:
  name: board_status

sources:
  - hw/board_status_pkg.sv
  - hw/lock_reset_sync.sv
  - hw/led_input_sync.sv
  - hw/led_sreg_driver.sv
  - hw/board_status_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_board_status.sv
